// ==== include/soc_bus_cfg.svh ====
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define ID_W 2

// address map, top nibble of the address
`define REGION_MEM 0
`define REGION_LED 2

// word memory, index from address bits 5..2
`define MEM_WORDS 16

// cycles a button must stay high before a press counts
`define BTN_STABLE 4

// status byte pages on the led display
`define STATUS_PAGES 8

`endif

// ==== hdl/bus_pkg.sv ====
`include "soc_bus_cfg.svh"

package bus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } bus_resp_e;

    typedef struct packed {
        bus_op_e              op;
        logic [`ID_W-1:0]     id;
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W-1:0]   wdata;
        logic [`DATA_W/8-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] rdata;
        bus_resp_e          resp;
    } bus_rsp_t;

    // byte lanes with strobe set take the new data
    function automatic logic [`DATA_W-1:0] strb_merge(
        input logic [`DATA_W-1:0]   old_word,
        input logic [`DATA_W-1:0]   new_word,
        input logic [`DATA_W/8-1:0] strb
    );
        logic [`DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < `DATA_W/8; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== hdl/status_pkg.sv ====
`include "soc_bus_cfg.svh"

package status_pkg;

    // selects one status byte
    typedef logic [$clog2(`STATUS_PAGES)-1:0] page_idx_t;

    // page 0 at bits 7..0
    typedef logic [`STATUS_PAGES-1:0][7:0] status_bytes_t;

endpackage

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic       sys_clk,
    input  logic       arst_n,
    input  bus_req_t   m_req [2],
    input  logic [1:0] m_req_valid,
    output logic [1:0] m_req_ready,
    output bus_rsp_t   m_rsp [2],
    output logic [1:0] m_rsp_valid,
    input  logic [1:0] m_rsp_ready,
    output bus_req_t   s_req,
    output logic       s_req_valid,
    input  logic       s_req_ready,
    input  bus_rsp_t   s_rsp,
    input  logic       s_rsp_valid,
    output logic       s_rsp_ready,
    output logic       grant_evt,
    output logic       grant_master
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    arb_state_e state;
    logic       owner;
    logic       last_win;
    logic       req_sent;  // request already passed on
    logic       pick;
    logic       busy;

    // on contention the master not granted last wins
    assign pick = (&m_req_valid) ? ~last_win : m_req_valid[1];
    assign busy = (state == ARB_BUSY);
    assign grant_master = owner;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            owner     <= 1'b0;
            last_win  <= 1'b1;  // so master 0 goes first
            req_sent  <= 1'b0;
            grant_evt <= 1'b0;
        end else begin
            grant_evt <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (|m_req_valid) begin
                        state     <= ARB_BUSY;
                        owner     <= pick;
                        last_win  <= pick;
                        req_sent  <= 1'b0;
                        grant_evt <= 1'b1;
                    end
                end
                ARB_BUSY: begin
                    if (s_req_valid && s_req_ready) req_sent <= 1'b1;
                    // hold grant until the response is taken
                    if (s_rsp_valid && s_rsp_ready) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        s_req              = m_req[owner];
        s_req_valid        = busy && !req_sent && m_req_valid[owner];
        s_rsp_ready        = busy && m_rsp_ready[owner];
        m_req_ready        = '0;
        m_rsp_valid        = '0;
        m_req_ready[owner] = busy && !req_sent && s_req_ready;
        m_rsp_valid[owner] = busy && s_rsp_valid;
        for (int i = 0; i < 2; i++) begin
            m_rsp[i] = s_rsp;
        end
    end

endmodule

// ==== hdl/addr_decoder.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module addr_decoder
    import bus_pkg::*;
(
    input  logic     sys_clk,
    input  logic     arst_n,
    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output bus_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    input  bus_rsp_t mem_rsp,
    input  logic     mem_rsp_valid,
    output logic     mem_rsp_ready,
    output bus_req_t led_req,
    output logic     led_req_valid,
    input  logic     led_req_ready,
    input  bus_rsp_t led_rsp,
    input  logic     led_rsp_valid,
    output logic     led_rsp_ready,
    output logic       done_evt,
    output logic [1:0] done_region,
    output logic       done_err
);

    logic [3:0]       region;
    logic [1:0]       region_clip;
    logic             hit_mem;
    logic             hit_led;
    logic             busy;
    logic [1:0]       tgt;     // region of the pending transfer
    logic [`ID_W-1:0] err_id;
    logic             accept;

    assign region      = req.addr[`ADDR_W-1 -: 4];
    assign region_clip = (region > 4'd3) ? 2'd3 : region[1:0];
    assign hit_mem     = (region == 4'(`REGION_MEM));
    assign hit_led     = (region == 4'(`REGION_LED));

    assign mem_req       = req;
    assign led_req       = req;
    assign mem_req_valid = req_valid && !busy && hit_mem;
    assign led_req_valid = req_valid && !busy && hit_led;

    // unmapped regions are taken by the decoder itself
    assign req_ready = !busy && (hit_mem ? mem_req_ready : (hit_led ? led_req_ready : 1'b1));
    assign accept    = req_valid && req_ready;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            tgt  <= 2'd0;
        end else if (accept) begin
            busy <= 1'b1;
            tgt  <= region_clip;
        end else if (rsp_valid && rsp_ready) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) err_id <= req.id;
    end

    always_comb begin
        rsp.id        = err_id;
        rsp.rdata     = '0;
        rsp.resp      = RESP_DECERR;
        rsp_valid     = busy;  // error answer one cycle after accept
        mem_rsp_ready = 1'b0;
        led_rsp_ready = 1'b0;
        if (tgt == 2'(`REGION_MEM)) begin
            rsp           = mem_rsp;
            rsp_valid     = busy && mem_rsp_valid;
            mem_rsp_ready = busy && rsp_ready;
        end else if (tgt == 2'(`REGION_LED)) begin
            rsp           = led_rsp;
            rsp_valid     = busy && led_rsp_valid;
            led_rsp_ready = busy && rsp_ready;
        end
    end

    assign done_evt    = rsp_valid && rsp_ready;
    assign done_region = tgt;
    assign done_err    = (rsp.resp != RESP_OKAY);

endmodule

// ==== hdl/mem_slave.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module mem_slave
    import bus_pkg::*;
(
    input  logic     sys_clk,
    input  logic     arst_n,
    input  bus_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output bus_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic [IDX_W-1:0]   idx;
    logic               accept;

    assign idx       = req.addr[2 +: IDX_W];  // higher bits alias
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // cleared on reset, the ddr stand-in starts out zeroed
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < `MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (accept && req.op == OP_WRITE) begin
            mem[idx] <= strb_merge(mem[idx], req.wdata, req.strb);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            rsp.id    <= req.id;
            rsp.resp  <= RESP_OKAY;
            rsp.rdata <= (req.op == OP_READ) ? mem[idx] : '0;  // old word on read
        end
    end

endmodule

// ==== hdl/led_slave.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module led_slave
    import bus_pkg::*;
(
    input  logic               sys_clk,
    input  logic               arst_n,
    input  bus_req_t           req,
    input  logic               req_valid,
    output logic               req_ready,
    output bus_rsp_t           rsp,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output logic [`DATA_W-1:0] led_reg
);

    logic accept;

    assign req_ready = !rsp_valid;  // one outstanding response
    assign accept    = req_valid && req_ready;

    // whole region maps onto the one register
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            led_reg   <= '0;
        end else begin
            if (accept) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            if (accept && req.op == OP_WRITE) begin
                led_reg <= strb_merge(led_reg, req.wdata, req.strb);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            rsp.id    <= req.id;
            rsp.resp  <= RESP_OKAY;
            rsp.rdata <= (req.op == OP_READ) ? led_reg : '0;
        end
    end

endmodule

// ==== hdl/status_display.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module status_display
    import status_pkg::*;
(
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic       grant_evt,
    input  logic       grant_master,
    input  logic       done_evt,
    input  logic [1:0] done_region,
    input  logic       done_err,
    input  logic [7:0] led_byte,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    localparam int CNT_W = $clog2(`BTN_STABLE + 1);
    localparam int N_EVT = `STATUS_PAGES - 1;  // last page is the led byte

    logic [1:0]            btn;
    logic [1:0][CNT_W-1:0] hold_cnt;
    logic [1:0]            press;
    page_idx_t             page;
    page_idx_t             page_nxt;
    logic [N_EVT-1:0][7:0] ev_cnt;
    logic [N_EVT-1:0][7:0] ev_nxt;
    status_bytes_t         bytes_nxt;

    assign btn = {btn_down, btn_up};

    // fires on the BTN_STABLE-th high sample, then the counter parks
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            press[i] = btn[i] && (hold_cnt[i] == CNT_W'(`BTN_STABLE - 1));
        end
    end

    always_comb begin
        case (press)
            2'b01:   page_nxt = page + 1'b1;
            2'b10:   page_nxt = page - 1'b1;
            default: page_nxt = page;  // none, or both at once
        endcase
    end

    always_comb begin
        ev_nxt = ev_cnt;
        if (grant_evt) begin
            ev_nxt[grant_master] = ev_cnt[grant_master] + 8'd1;
        end
        if (done_evt) begin
            ev_nxt[2 + done_region] = ev_cnt[2 + done_region] + 8'd1;
            if (done_err) ev_nxt[N_EVT-1] = ev_cnt[N_EVT-1] + 8'd1;
        end
    end

    assign bytes_nxt = {led_byte, ev_nxt};

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt <= '0;
            page     <= '0;
            ev_cnt   <= '0;
            led4     <= '0;
            led8     <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!btn[i]) begin
                    hold_cnt[i] <= '0;
                end else if (hold_cnt[i] != CNT_W'(`BTN_STABLE)) begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1;
                end
            end
            page   <= page_nxt;
            ev_cnt <= ev_nxt;
            led4   <= {1'b0, page_nxt};
            led8   <= bytes_nxt[page_nxt];
        end
    end

endmodule

// ==== hdl/soc_bus_top.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module soc_bus_top
    import bus_pkg::*;
(
    input  logic       sys_clk,
    input  logic       arst_n,
    input  bus_req_t   m0_req,
    input  logic       m0_req_valid,
    output logic       m0_req_ready,
    output bus_rsp_t   m0_rsp,
    output logic       m0_rsp_valid,
    input  logic       m0_rsp_ready,
    input  bus_req_t   m1_req,
    input  logic       m1_req_valid,
    output logic       m1_req_ready,
    output bus_rsp_t   m1_rsp,
    output logic       m1_rsp_valid,
    input  logic       m1_rsp_ready,
    input  logic [1:0] btn,   // 0 up, 1 down
    output logic [7:0] led8,
    output logic [3:0] led4
);

    bus_req_t           m_req [2];
    bus_rsp_t           m_rsp [2];
    logic [1:0]         m_req_ready;
    logic [1:0]         m_rsp_valid;
    bus_req_t           dec_req, mem_req, led_req;
    bus_rsp_t           dec_rsp, mem_rsp, led_rsp;
    logic               dec_req_valid, dec_req_ready, dec_rsp_valid, dec_rsp_ready;
    logic               mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    logic               led_req_valid, led_req_ready, led_rsp_valid, led_rsp_ready;
    logic               grant_evt, grant_master;
    logic               done_evt, done_err;
    logic [1:0]         done_region;
    logic [`DATA_W-1:0] led_reg;

    assign m_req[0]     = m0_req;
    assign m_req[1]     = m1_req;
    assign m0_rsp       = m_rsp[0];
    assign m1_rsp       = m_rsp[1];
    assign m0_req_ready = m_req_ready[0];
    assign m1_req_ready = m_req_ready[1];
    assign m0_rsp_valid = m_rsp_valid[0];
    assign m1_rsp_valid = m_rsp_valid[1];

    bus_arbiter u_bus_arbiter (
        .sys_clk      (sys_clk),
        .arst_n       (arst_n),
        .m_req        (m_req),
        .m_req_valid  ({m1_req_valid, m0_req_valid}),
        .m_req_ready  (m_req_ready),
        .m_rsp        (m_rsp),
        .m_rsp_valid  (m_rsp_valid),
        .m_rsp_ready  ({m1_rsp_ready, m0_rsp_ready}),
        .s_req        (dec_req),
        .s_req_valid  (dec_req_valid),
        .s_req_ready  (dec_req_ready),
        .s_rsp        (dec_rsp),
        .s_rsp_valid  (dec_rsp_valid),
        .s_rsp_ready  (dec_rsp_ready),
        .grant_evt    (grant_evt),
        .grant_master (grant_master)
    );

    addr_decoder u_addr_decoder (
        .sys_clk       (sys_clk),
        .arst_n        (arst_n),
        .req           (dec_req),
        .req_valid     (dec_req_valid),
        .req_ready     (dec_req_ready),
        .rsp           (dec_rsp),
        .rsp_valid     (dec_rsp_valid),
        .rsp_ready     (dec_rsp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .led_req       (led_req),
        .led_req_valid (led_req_valid),
        .led_req_ready (led_req_ready),
        .led_rsp       (led_rsp),
        .led_rsp_valid (led_rsp_valid),
        .led_rsp_ready (led_rsp_ready),
        .done_evt      (done_evt),
        .done_region   (done_region),
        .done_err      (done_err)
    );

    mem_slave u_mem_slave (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .req       (mem_req),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .rsp       (mem_rsp),
        .rsp_valid (mem_rsp_valid),
        .rsp_ready (mem_rsp_ready)
    );

    led_slave u_led_slave (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .req       (led_req),
        .req_valid (led_req_valid),
        .req_ready (led_req_ready),
        .rsp       (led_rsp),
        .rsp_valid (led_rsp_valid),
        .rsp_ready (led_rsp_ready),
        .led_reg   (led_reg)
    );

    status_display u_status_display (
        .sys_clk      (sys_clk),
        .arst_n       (arst_n),
        .btn_up       (btn[0]),
        .btn_down     (btn[1]),
        .grant_evt    (grant_evt),
        .grant_master (grant_master),
        .done_evt     (done_evt),
        .done_region  (done_region),
        .done_err     (done_err),
        .led_byte     (led_reg[7:0]),
        .led8         (led8),
        .led4         (led4)
    );

endmodule

// ==== testbench/tb_soc_bus.sv ====
`timescale 1ns/10ps
`include "soc_bus_cfg.svh"

module tb_soc_bus
    import bus_pkg::*, status_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;  // about 850 cycles of tests, wide margin

    logic       sys_clk;
    logic       arst_n;
    bus_req_t   mreq [2];
    bus_rsp_t   mrsp [2];
    logic [1:0] mreq_valid;
    logic [1:0] mreq_ready;
    logic [1:0] mrsp_valid;
    logic [1:0] mrsp_ready;
    logic [1:0] btn;
    logic [7:0] led8;
    logic [3:0] led4;

    // reference model
    logic [`DATA_W-1:0] mem_model [`MEM_WORDS];
    logic [`DATA_W-1:0] led_model;
    logic [1:0][7:0]    grants;
    logic [3:0][7:0]    dones;
    logic [7:0]         errs;
    page_idx_t          page_model;
    int                 last_grant;
    int                 order [$];  // masters in completion order

    logic [31:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_bad;

    soc_bus_top u_soc_bus_top (
        .sys_clk      (sys_clk),
        .arst_n       (arst_n),
        .m0_req       (mreq[0]),
        .m0_req_valid (mreq_valid[0]),
        .m0_req_ready (mreq_ready[0]),
        .m0_rsp       (mrsp[0]),
        .m0_rsp_valid (mrsp_valid[0]),
        .m0_rsp_ready (mrsp_ready[0]),
        .m1_req       (mreq[1]),
        .m1_req_valid (mreq_valid[1]),
        .m1_req_ready (mreq_ready[1]),
        .m1_rsp       (mrsp[1]),
        .m1_rsp_valid (mrsp_valid[1]),
        .m1_rsp_ready (mrsp_ready[1]),
        .btn          (btn),
        .led8         (led8),
        .led4         (led4)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    task automatic note_mismatch(input string msg);
        errors++;
        test_errs++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else note_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    // held response must not change while it waits
    hold_rsp_0: assert property (@(posedge sys_clk) disable iff (!arst_n)
        mrsp_valid[0] && !mrsp_ready[0] |=> mrsp_valid[0] && $stable(mrsp[0]))
    else note_mismatch("master 0 response changed under back-pressure");

    hold_rsp_1: assert property (@(posedge sys_clk) disable iff (!arst_n)
        mrsp_valid[1] && !mrsp_ready[1] |=> mrsp_valid[1] && $stable(mrsp[1]))
    else note_mismatch("master 1 response changed under back-pressure");

    // a held response blocks every request, the owner's included
    no_grant_held: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (mrsp_valid & ~mrsp_ready) != 2'b00 |-> mreq_ready == 2'b00)
    else note_mismatch("request accepted while a response is held");

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_next();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_next()};
        end
        return r;
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0]  s);
        logic [31:0] mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [7:0] page_byte(input page_idx_t p);
        case (p)
            3'd0:    return grants[0];
            3'd1:    return grants[1];
            3'd6:    return errs;
            3'd7:    return led_model[7:0];
            default: return dones[p - 3'd2];
        endcase
    endfunction

    // one full transaction on master m, called just after a rising edge
    task automatic xfer(input int m, input bus_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] strb,
                        input logic [1:0] id, input int hold);
        bus_req_t    rq;
        bus_rsp_t    rs;
        logic [3:0]  region;
        logic [3:0]  idx;
        logic [31:0] exp_rdata;
        bus_resp_e   exp_resp;
        region    = addr[31:28];
        idx       = addr[5:2];
        exp_rdata = '0;
        exp_resp  = RESP_DECERR;
        if (region == `REGION_MEM || region == `REGION_LED) exp_resp = RESP_OKAY;
        if (op == OP_READ && region == `REGION_MEM) exp_rdata = mem_model[idx];
        if (op == OP_READ && region == `REGION_LED) exp_rdata = led_model;
        rq.op         = op;
        rq.id         = id;
        rq.addr       = addr;
        rq.wdata      = wdata;
        rq.strb       = strb;
        mreq[m]       = rq;
        mreq_valid[m] = 1'b1;
        mrsp_ready[m] = (hold == 0);
        @(negedge sys_clk);
        while (!mreq_ready[m]) @(negedge sys_clk);
        @(posedge sys_clk);
        #2;
        mreq_valid[m] = 1'b0;
        @(negedge sys_clk);
        while (!mrsp_valid[m]) @(negedge sys_clk);
        repeat (hold) @(negedge sys_clk);
        rs = mrsp[m];
        if (hold > 0) begin
            @(posedge sys_clk);
            #2;
            mrsp_ready[m] = 1'b1;
        end
        @(posedge sys_clk);
        #2;
        check_value($sformatf("m%0d rsp id", m), rs.id, id);
        check_value($sformatf("m%0d rsp resp", m), rs.resp, exp_resp);
        check_value($sformatf("m%0d rsp rdata", m), rs.rdata, exp_rdata);
        grants[m]++;
        dones[(region > 4'd3) ? 2'd3 : region[1:0]]++;
        if (exp_resp != RESP_OKAY) errs++;
        if (op == OP_WRITE && region == `REGION_MEM) begin
            mem_model[idx] = apply_strobes(mem_model[idx], wdata, strb);
        end
        if (op == OP_WRITE && region == `REGION_LED) begin
            led_model = apply_strobes(led_model, wdata, strb);
        end
        order.push_back(m);
        last_grant = m;
    endtask

    task automatic sweep_memory();
        for (int w = 0; w < `MEM_WORDS; w++) begin
            xfer(w % 2, OP_READ, {26'h0, 4'(w), 2'b00}, 32'h0, 4'h0, 2'(w), 0);
        end
    endtask

    task automatic press_button(input int b, input int len);
        btn[b] = 1'b1;
        repeat (len) @(posedge sys_clk);
        #2;
        btn[b] = 1'b0;
        repeat (2) @(posedge sys_clk);
        #2;
        if (len >= `BTN_STABLE) page_model = (b == 0) ? page_model + 1'b1 : page_model - 1'b1;
    endtask

    task automatic check_page();
        @(negedge sys_clk);
        check_value("led4", led4, page_model);
        check_value("led8", led8, page_byte(page_model));
        @(posedge sys_clk);
        #2;
    endtask

    task automatic show_page(input page_idx_t p);
        while (page_model != p) press_button(0, `BTN_STABLE);
        check_page();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] alias_bits;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [3:0]  idx;
        logic [3:0]  strb;
        logic [1:0]  id;
        logic [1:0]  id0;
        logic [1:0]  id1;
        int          last_before;
        arst_n     = 1'b0;
        mreq[0]    = '0;
        mreq[1]    = '0;
        mreq_valid = '0;
        mrsp_ready = 2'b11;
        btn        = '0;
        lfsr       = 32'hd82f_96d0;
        led_model  = '0;
        grants     = '0;
        dones      = '0;
        errs       = '0;
        page_model = '0;
        last_grant = 1;  // master 0 wins the first contention
        checks     = 0;
        errors     = 0;
        test_errs  = 0;
        tests_run  = 0;
        tests_bad  = 0;
        for (int w = 0; w < `MEM_WORDS; w++) mem_model[w] = '0;
        repeat (8) @(posedge sys_clk);
        #2;
        arst_n = 1'b1;

        @(negedge sys_clk);
        check_value("req_ready", mreq_ready, 2'b00);
        check_value("rsp_valid", mrsp_valid, 2'b00);
        check_value("led4", led4, 4'h0);
        check_value("led8", led8, 8'h00);
        @(posedge sys_clk);
        #2;
        finish_test("reset_state");

        for (int i = 0; i < 8; i++) begin
            idx        = rand_bits(4);
            alias_bits = rand_bits(22);
            wdata      = rand_bits(32);
            strb       = rand_bits(4);
            id         = rand_bits(2);
            xfer(i % 2, OP_WRITE, {4'h0, alias_bits[21:0], idx, 2'b00}, wdata, strb, id, 0);
            alias_bits = rand_bits(22);  // other alias of the same word
            id         = rand_bits(2);
            xfer((i + 1) % 2, OP_READ, {4'h0, alias_bits[21:0], idx, 2'b00}, 32'h0, 4'h0, id, 0);
        end
        sweep_memory();
        finish_test("memory_access");

        alias_bits = rand_bits(28);
        addr       = {4'h2, alias_bits[27:0]};
        wdata      = rand_bits(32);
        xfer(0, OP_WRITE, addr, wdata, 4'hf, 2'd1, 0);
        alias_bits = rand_bits(28);
        xfer(1, OP_READ, {4'h2, alias_bits[27:0]}, 32'h0, 4'h0, 2'd2, 0);
        wdata = rand_bits(32);
        xfer(1, OP_WRITE, addr, wdata, 4'b0101, 2'd3, 0);
        xfer(0, OP_READ, addr, 32'h0, 4'h0, 2'd0, 0);
        show_page(3'd7);
        finish_test("led_register");

        for (int n = 1; n < 16; n++) begin
            if (n != `REGION_LED) begin
                alias_bits = rand_bits(28);
                wdata      = rand_bits(32);
                id         = rand_bits(2);
                xfer(n % 2, (n % 2 == 1) ? OP_WRITE : OP_READ,
                     {4'(n), alias_bits[27:0]}, wdata, 4'hf, id, 0);
            end
        end
        sweep_memory();  // error writes must not have reached memory
        show_page(3'd6);
        finish_test("decode_errors");

        order.delete();
        last_before = last_grant;
        for (int r = 0; r < 5; r++) begin
            alias_bits = rand_bits(28);
            a0         = {4'h0, alias_bits[27:0]};
            alias_bits = rand_bits(28);
            a1         = (r == 4) ? {4'h2, alias_bits[27:0]} : {4'h0, alias_bits[27:0]};
            id0        = rand_bits(2);
            id1        = rand_bits(2);
            // each second request meets the other master still waiting
            fork
                repeat (2) xfer(0, OP_READ, a0, 32'h0, 4'h0, id0, (r == 4) ? 3 : 0);
                repeat (2) xfer(1, OP_READ, a1, 32'h0, 4'h0, id1, (r == 4) ? 2 : 0);
            join
        end
        check_value("first grant", order[0], 1 - last_before);
        for (int k = 1; k < order.size(); k++) begin
            check_value("grant order", order[k], 1 - order[k - 1]);
        end
        for (int p = 0; p < 6; p++) begin
            show_page(3'(p));
        end
        finish_test("arbitration");

        show_page(3'd0);
        press_button(0, `BTN_STABLE - 1);  // too short to count
        check_page();
        press_button(1, `BTN_STABLE);
        check_value("led4 after down", led4, 4'd7);
        check_page();
        press_button(0, `BTN_STABLE);
        check_page();
        finish_test("button_handling");

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hdl/bus_pkg.sv
hdl/status_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/mem_slave.sv
hdl/led_slave.sv
hdl/status_display.sv
hdl/soc_bus_top.sv
testbench/tb_soc_bus.sv

// ==== Makefile ====
SRCS := $(shell grep '\.sv$$' flist.f) include/soc_bus_cfg.svh

obj_dir/Vtb_soc_bus: flist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_soc_bus -f flist.f

run: obj_dir/Vtb_soc_bus
	@out=$$(./obj_dir/Vtb_soc_bus); echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir

.PHONY: run clean
